/* design/afu_pkg.sv */
`default_nettype none

package afu_pkg;

    // ==================================================
    // Sizes
    // ==================================================

    localparam int NUM_ENGINES     = 2;
    localparam int DATA_W          = 64;
    localparam int HADDR_W         = 16;
    localparam int MMIO_ADDR_W     = 8;
    localparam int CNT_W           = 16;
    localparam int MAX_OUTSTANDING = 4;
    // Wide enough to hold MAX_OUTSTANDING itself
    localparam int OUTST_W         = $clog2(MAX_OUTSTANDING + 1);

    // ==================================================
    // CSR map
    // ==================================================

    // Identifies this exercise block to software
    localparam logic [127:0] TEST_ID = 128'h3d9f7a12_6c0e_4b58_9a21_e47b05c8f136;

    // Top address bit picks an engine page over the global page
    localparam int CSR_PAGE_BIT = MMIO_ADDR_W - 1;
    localparam int GLOB_IDX_W   = CSR_PAGE_BIT;
    localparam int ENG_IDX_W    = 3;
    localparam int ENG_OFF_W    = CSR_PAGE_BIT - ENG_IDX_W;

    localparam logic [GLOB_IDX_W-1:0] GLOB_CSR_ID_LO  = GLOB_IDX_W'(0);
    localparam logic [GLOB_IDX_W-1:0] GLOB_CSR_ID_HI  = GLOB_IDX_W'(1);
    localparam logic [GLOB_IDX_W-1:0] GLOB_CSR_NUM_EN = GLOB_IDX_W'(2);

    // Offset 1 is the read base on writes and the checksum on reads
    localparam logic [ENG_OFF_W-1:0] ENG_CSR_CTRL       = ENG_OFF_W'(0);
    localparam logic [ENG_OFF_W-1:0] ENG_CSR_RD_BASE    = ENG_OFF_W'(1);
    localparam logic [ENG_OFF_W-1:0] ENG_CSR_WR_BASE    = ENG_OFF_W'(2);
    localparam logic [ENG_OFF_W-1:0] ENG_CSR_NUM_LINES  = ENG_OFF_W'(3);
    localparam logic [ENG_OFF_W-1:0] ENG_CSR_CHECKSUM   = ENG_OFF_W'(1);
    // Read base comes back at its own read-only offset
    localparam logic [ENG_OFF_W-1:0] ENG_CSR_RD_BASE_RB = ENG_OFF_W'(4);

    // Layout of the status word read at ENG_CSR_CTRL
    localparam int STAT_ACTIVE_BIT = 0;
    localparam int STAT_LINES_LSB  = 16;

    // ==================================================
    // Types
    // ==================================================

    typedef struct packed {
        logic                  page;
        logic [GLOB_IDX_W-1:0] idx;
    } mmio_glob_addr_t;

    typedef struct packed {
        logic                 page;
        logic [ENG_IDX_W-1:0] idx;
        logic [ENG_OFF_W-1:0] off;
    } mmio_eng_addr_t;

    // The same MMIO word seen as a global index or as engine plus offset
    typedef union packed {
        mmio_glob_addr_t glob;
        mmio_eng_addr_t  eng;
    } mmio_addr_u;

    typedef struct packed {
        logic              read;
        logic              write;
        mmio_addr_u        address;
        logic [DATA_W-1:0] writedata;
    } mmio_req_t;

    typedef struct packed {
        logic              readdatavalid;
        logic [DATA_W-1:0] readdata;
    } mmio_rsp_t;

    typedef struct packed {
        logic               start;
        logic [HADDR_W-1:0] rd_base;
        logic [HADDR_W-1:0] wr_base;
        logic [CNT_W-1:0]   num_lines;
    } eng_cfg_t;

    typedef struct packed {
        logic              active;
        logic [CNT_W-1:0]  lines_done;
        logic [DATA_W-1:0] checksum;
    } eng_stat_t;

    // Reads and writes can issue together so each has its own line address
    typedef struct packed {
        logic [HADDR_W-1:0] rd;
        logic [HADDR_W-1:0] wr;
    } host_addr_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        host_addr_t        addr;
        logic [DATA_W-1:0] wdata;
    } host_mem_req_t;

    typedef struct packed {
        logic              rd_valid;
        logic [DATA_W-1:0] rdata;
    } host_mem_rsp_t;

endpackage

`default_nettype wire

/* design/afu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module afu_top
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  afu_pkg::mmio_req_t      mmio_req,
    output afu_pkg::mmio_rsp_t      mmio_rsp,
    output afu_pkg::host_mem_req_t  host_mem_req [afu_pkg::NUM_ENGINES],
    input  afu_pkg::host_mem_rsp_t  host_mem_rsp [afu_pkg::NUM_ENGINES]
);

    // Per-engine control and status between the CSR block and the engines
    afu_pkg::eng_cfg_t   eng_cfg  [afu_pkg::NUM_ENGINES];
    afu_pkg::eng_stat_t  eng_stat [afu_pkg::NUM_ENGINES];

    // ==================================================
    // CSR manager
    // ==================================================

    csr_mgr u_csr_mgr
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .eng_cfg  (eng_cfg),
        .eng_stat (eng_stat)
    );

    // ==================================================
    // Copy engines
    // ==================================================

    // One engine per host memory port, each told its own number
    for (genvar e = 0; e < afu_pkg::NUM_ENGINES; e++)
    begin : g_eng
        mem_copy_engine u_eng
        (
            .clk          (clk),
            .rst_n        (rst_n),
            .eng_index    (afu_pkg::ENG_IDX_W'(e)),
            .cfg          (eng_cfg[e]),
            .stat         (eng_stat[e]),
            .host_mem_req (host_mem_req[e]),
            .host_mem_rsp (host_mem_rsp[e])
        );
    end

endmodule

`default_nettype wire

/* design/csr_mgr.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_mgr
(
    input  logic                clk,
    input  logic                rst_n,
    input  afu_pkg::mmio_req_t  mmio_req,
    output afu_pkg::mmio_rsp_t  mmio_rsp,
    output afu_pkg::eng_cfg_t   eng_cfg [afu_pkg::NUM_ENGINES],
    input  afu_pkg::eng_stat_t  eng_stat [afu_pkg::NUM_ENGINES]
);

    afu_pkg::mmio_addr_u               addr;
    logic [afu_pkg::NUM_ENGINES-1:0]   eng_sel;
    logic [afu_pkg::DATA_W-1:0]        rd_mux;
    logic                              rsp_valid_q;
    logic [afu_pkg::DATA_W-1:0]        rsp_data_q;

    assign addr = mmio_req.address;

    // ==================================================
    // Address decode
    // ==================================================

    // An engine page is hit only when the page bit is set and the index matches
    // Indices past the last engine select nothing and read back as zero
    always_comb
    begin
        for (int e = 0; e < afu_pkg::NUM_ENGINES; e++)
        begin
            eng_sel[e] = addr.eng.page && (addr.eng.idx == afu_pkg::ENG_IDX_W'(e));
        end
    end

    // ==================================================
    // Engine configuration registers
    // ==================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int e = 0; e < afu_pkg::NUM_ENGINES; e++)
            begin
                eng_cfg[e] <= '0;
            end
        end
        else
        begin
            for (int e = 0; e < afu_pkg::NUM_ENGINES; e++)
            begin
                // Start drops again one cycle after it was written
                eng_cfg[e].start <= 1'b0;

                if (mmio_req.write && eng_sel[e])
                begin
                    case (addr.eng.off)
                        afu_pkg::ENG_CSR_CTRL:
                            eng_cfg[e].start <= mmio_req.writedata[0];
                        afu_pkg::ENG_CSR_RD_BASE:
                            eng_cfg[e].rd_base <= mmio_req.writedata[afu_pkg::HADDR_W-1:0];
                        afu_pkg::ENG_CSR_WR_BASE:
                            eng_cfg[e].wr_base <= mmio_req.writedata[afu_pkg::HADDR_W-1:0];
                        afu_pkg::ENG_CSR_NUM_LINES:
                            eng_cfg[e].num_lines <= mmio_req.writedata[afu_pkg::CNT_W-1:0];
                        default:
                            ;
                    endcase
                end
            end
        end
    end

    // ==================================================
    // Read multiplexer
    // ==================================================

    always_comb
    begin
        rd_mux = '0;

        if (!addr.glob.page)
        begin
            // Global page tells software what it is talking to
            case (addr.glob.idx)
                afu_pkg::GLOB_CSR_ID_LO:
                    rd_mux = afu_pkg::TEST_ID[afu_pkg::DATA_W-1:0];
                afu_pkg::GLOB_CSR_ID_HI:
                    rd_mux = afu_pkg::TEST_ID[2*afu_pkg::DATA_W-1:afu_pkg::DATA_W];
                afu_pkg::GLOB_CSR_NUM_EN:
                    rd_mux = afu_pkg::DATA_W'(afu_pkg::NUM_ENGINES);
                default:
                    rd_mux = '0;
            endcase
        end
        else
        begin
            for (int e = 0; e < afu_pkg::NUM_ENGINES; e++)
            begin
                if (eng_sel[e])
                begin
                    case (addr.eng.off)
                        afu_pkg::ENG_CSR_CTRL:
                        begin
                            // Status packs the busy flag and the completed line count
                            rd_mux[afu_pkg::STAT_ACTIVE_BIT] = eng_stat[e].active;
                            rd_mux[afu_pkg::STAT_LINES_LSB +: afu_pkg::CNT_W] =
                                eng_stat[e].lines_done;
                        end
                        afu_pkg::ENG_CSR_CHECKSUM:
                            rd_mux = eng_stat[e].checksum;
                        afu_pkg::ENG_CSR_WR_BASE:
                            rd_mux = afu_pkg::DATA_W'(eng_cfg[e].wr_base);
                        afu_pkg::ENG_CSR_NUM_LINES:
                            rd_mux = afu_pkg::DATA_W'(eng_cfg[e].num_lines);
                        afu_pkg::ENG_CSR_RD_BASE_RB:
                            rd_mux = afu_pkg::DATA_W'(eng_cfg[e].rd_base);
                        default:
                            rd_mux = '0;
                    endcase
                end
            end
        end
    end

    // ==================================================
    // Read response
    // ==================================================

    // Valid follows the read strobe by exactly one cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= mmio_req.read;
        end
    end

    // Data is only meaningful alongside valid
    always_ff @(posedge clk)
    begin
        if (mmio_req.read)
        begin
            rsp_data_q <= rd_mux;
        end
    end

    assign mmio_rsp.readdatavalid = rsp_valid_q;
    assign mmio_rsp.readdata      = rsp_data_q;

endmodule

`default_nettype wire

/* design/mem_copy_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_copy_engine
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [afu_pkg::ENG_IDX_W-1:0]   eng_index,
    input  afu_pkg::eng_cfg_t               cfg,
    output afu_pkg::eng_stat_t              stat,
    output afu_pkg::host_mem_req_t          host_mem_req,
    input  afu_pkg::host_mem_rsp_t          host_mem_rsp
);

    // Copy parameters latched when a run begins
    logic [afu_pkg::HADDR_W-1:0]  rd_base_q;
    logic [afu_pkg::HADDR_W-1:0]  wr_base_q;
    logic [afu_pkg::CNT_W-1:0]    num_lines_q;

    // Run state
    logic                         active_q;
    logic [afu_pkg::CNT_W-1:0]    issue_cnt;
    logic [afu_pkg::CNT_W-1:0]    ret_cnt;
    logic [afu_pkg::OUTST_W-1:0]  outst_cnt;
    logic [afu_pkg::DATA_W-1:0]   checksum_q;

    logic                         start_ok;
    logic                         rd_issue;
    logic                         rd_ret;
    logic [afu_pkg::CNT_W-1:0]    ret_next;
    logic                         done;

    // ==================================================
    // Issue and completion control
    // ==================================================

    // A start that arrives mid-run is dropped
    assign start_ok = cfg.start && !active_q;

    // Returned data only counts while a run is active
    assign rd_ret = active_q && host_mem_rsp.rd_valid;

    // Issue one read per cycle until all lines are requested or the window is full
    assign rd_issue = active_q
                   && (issue_cnt != num_lines_q)
                   && (outst_cnt < afu_pkg::OUTST_W'(afu_pkg::MAX_OUTSTANDING));

    assign ret_next = ret_cnt + afu_pkg::CNT_W'(rd_ret);

    // Finished once the returned count reaches the target
    // With zero lines this holds on the first active cycle
    assign done = active_q && (ret_next == num_lines_q);

    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            rd_base_q   <= cfg.rd_base;
            wr_base_q   <= cfg.wr_base;
            num_lines_q <= cfg.num_lines;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active_q   <= 1'b0;
            issue_cnt  <= '0;
            ret_cnt    <= '0;
            outst_cnt  <= '0;
            // Engine number sits in the top byte so software can tell engines apart
            checksum_q <= '0;
            checksum_q[afu_pkg::DATA_W-1 -: 8] <= 8'(eng_index);
        end
        else if (start_ok)
        begin
            active_q   <= 1'b1;
            issue_cnt  <= '0;
            ret_cnt    <= '0;
            outst_cnt  <= '0;
            checksum_q <= '0;
        end
        else if (active_q)
        begin
            if (rd_issue)
            begin
                issue_cnt <= issue_cnt + afu_pkg::CNT_W'(1);
            end

            if (rd_ret)
            begin
                ret_cnt    <= ret_next;
                checksum_q <= checksum_q ^ host_mem_rsp.rdata;
            end

            // Reads in flight go up on issue and down on return
            outst_cnt <= outst_cnt
                       + afu_pkg::OUTST_W'(rd_issue)
                       - afu_pkg::OUTST_W'(rd_ret);

            if (done)
            begin
                active_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // Host memory and status outputs
    // ==================================================

    // Returned data goes straight back out as a write in the same cycle
    always_comb
    begin
        host_mem_req.rd      = rd_issue;
        host_mem_req.addr.rd = rd_base_q + afu_pkg::HADDR_W'(issue_cnt);
        host_mem_req.wr      = rd_ret;
        host_mem_req.addr.wr = wr_base_q + afu_pkg::HADDR_W'(ret_cnt);
        host_mem_req.wdata   = host_mem_rsp.rdata;
    end

    // The return counter doubles as the completed line count
    assign stat.active     = active_q;
    assign stat.lines_done = ret_cnt;
    assign stat.checksum   = checksum_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_afu \
    -f sim.f -o tb_afu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_afu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

/* sim.f */
design/afu_pkg.sv
design/csr_mgr.sv
design/mem_copy_engine.sv
design/afu_top.sv
verif/host_mem_model.sv
verif/tb_afu.sv

/* verif/host_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module host_mem_model
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  afu_pkg::host_mem_req_t       host_mem_req [afu_pkg::NUM_ENGINES],
    output afu_pkg::host_mem_rsp_t       host_mem_rsp [afu_pkg::NUM_ENGINES],
    // Extra read latency per port, so a read takes 1 + lat_sel cycles
    input  logic [1:0]                   lat_sel [afu_pkg::NUM_ENGINES],
    input  logic                         fill_en,
    input  logic [afu_pkg::HADDR_W-1:0]  fill_addr,
    input  logic [afu_pkg::DATA_W-1:0]   fill_data
);

    // One array shared by every port, the testbench loads it through the fill port
    logic [afu_pkg::DATA_W-1:0] mem [0:(1 << afu_pkg::HADDR_W) - 1];
    int                         cyc = 0;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // ==================================================
    // Write path
    // ==================================================

    always @(posedge clk)
    begin
        if (fill_en)
        begin
            mem[fill_addr] <= fill_data;
        end
        for (int p = 0; p < afu_pkg::NUM_ENGINES; p++)
        begin
            if (host_mem_req[p].wr)
            begin
                mem[host_mem_req[p].addr.wr] <= host_mem_req[p].wdata;
            end
        end
    end

    // ==================================================
    // Read return, in order per port
    // ==================================================

    for (genvar p = 0; p < afu_pkg::NUM_ENGINES; p++)
    begin : g_port
        logic [afu_pkg::DATA_W-1:0] data_q [$];
        int                         due_q [$];
        int                         last_due;
        int                         due;
        afu_pkg::host_mem_rsp_t     rsp_q;

        always @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                data_q.delete();
                due_q.delete();
                last_due = -1;
                rsp_q <= '0;
            end
            else
            begin
                // A return never overtakes an older one and at most one comes back per cycle
                if (host_mem_req[p].rd)
                begin
                    due = cyc + int'(lat_sel[p]);
                    if (due <= last_due)
                    begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    data_q.push_back(mem[host_mem_req[p].addr.rd]);
                    due_q.push_back(due);
                end

                rsp_q.rd_valid <= 1'b0;
                if (due_q.size() > 0 && due_q[0] == cyc)
                begin
                    rsp_q.rd_valid <= 1'b1;
                    rsp_q.rdata    <= data_q.pop_front();
                    void'(due_q.pop_front());
                end
            end
        end

        assign host_mem_rsp[p] = rsp_q;
    end

endmodule

`default_nettype wire

/* verif/tb_afu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_afu;

    // Lines moved by all copy runs together size the timeout
    localparam int TOTAL_LINES    = 8 + 12 + 5 + 0 + 10 + 3;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_LINES + 2000;

    logic                          clk;
    logic                          rst_n;
    afu_pkg::mmio_req_t            mmio_req;
    afu_pkg::mmio_rsp_t            mmio_rsp;
    afu_pkg::host_mem_req_t        host_mem_req [afu_pkg::NUM_ENGINES];
    afu_pkg::host_mem_rsp_t        host_mem_rsp [afu_pkg::NUM_ENGINES];
    logic [1:0]                    lat_sel [afu_pkg::NUM_ENGINES];
    logic                          fill_en;
    logic [afu_pkg::HADDR_W-1:0]   fill_addr;
    logic [afu_pkg::DATA_W-1:0]    fill_data;

    logic [15:0]                   lfsr;
    // Expected memory contents keyed by line address
    logic [afu_pkg::DATA_W-1:0]    golden [int];
    int                            data_errors;
    int                            stat_errors;
    int                            count_errors;
    int                            other_errors;
    int                            cycles = 0;

    afu_top u_dut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_req     (mmio_req),
        .mmio_rsp     (mmio_rsp),
        .host_mem_req (host_mem_req),
        .host_mem_rsp (host_mem_rsp)
    );

    host_mem_model u_mem
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_mem_req (host_mem_req),
        .host_mem_rsp (host_mem_rsp),
        .lat_sel      (lat_sel),
        .fill_en      (fill_en),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    task automatic print_error_counts();
        $display("errors: data %0d, status %0d, count %0d, other %0d",
                 data_errors, stat_errors, count_errors, other_errors);
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_error_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ==================================================
    // Random numbers and drive helpers
    // ==================================================

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
        begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [afu_pkg::DATA_W-1:0] lfsr_bits(input int n);
        logic [afu_pkg::DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[afu_pkg::DATA_W-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Destination lines start with a pattern built from the whole line address
    function automatic logic [afu_pkg::DATA_W-1:0] addr_pattern(input int addr);
        logic [afu_pkg::HADDR_W-1:0] a;
        a = afu_pkg::HADDR_W'(addr);
        return {~a, a, ~a, a};
    endfunction

    // Every wait goes through here so fresh latencies are drawn each cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        for (int p = 0; p < afu_pkg::NUM_ENGINES; p++)
        begin
            lat_sel[p] = 2'(lfsr_bits(2));
        end
    endtask

    function automatic afu_pkg::mmio_addr_u glob_addr(input int idx);
        afu_pkg::mmio_addr_u a;
        a.glob.page = 1'b0;
        a.glob.idx  = afu_pkg::GLOB_IDX_W'(idx);
        return a;
    endfunction

    function automatic afu_pkg::mmio_addr_u eng_addr(input int e,
                                                     input logic [afu_pkg::ENG_OFF_W-1:0] off);
        afu_pkg::mmio_addr_u a;
        a.eng.page = 1'b1;
        a.eng.idx  = afu_pkg::ENG_IDX_W'(e);
        a.eng.off  = off;
        return a;
    endfunction

    task automatic mmio_write(input afu_pkg::mmio_addr_u addr,
                              input logic [afu_pkg::DATA_W-1:0] data);
        mmio_req.write     = 1'b1;
        mmio_req.address   = addr;
        mmio_req.writedata = data;
        next_cycle();
        mmio_req.write = 1'b0;
    endtask

    // Response must show up one cycle after the read and last for one cycle only
    task automatic mmio_read(input afu_pkg::mmio_addr_u addr,
                             output logic [afu_pkg::DATA_W-1:0] data);
        mmio_req.read    = 1'b1;
        mmio_req.address = addr;
        next_cycle();
        mmio_req.read = 1'b0;
        data = mmio_rsp.readdata;
        if (mmio_rsp.readdatavalid !== 1'b1)
        begin
            other_errors++;
            $display("MMIO read of word %h got no response one cycle later", addr);
        end
        next_cycle();
        if (mmio_rsp.readdatavalid !== 1'b0)
        begin
            other_errors++;
            $display("MMIO response for word %h stayed valid a second cycle", addr);
        end
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic compare_data(input string name, input logic [afu_pkg::DATA_W-1:0] expected,
                                input logic [afu_pkg::DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            data_errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_count(input string name, input logic [afu_pkg::CNT_W-1:0] expected,
                                 input logic [afu_pkg::CNT_W-1:0] actual);
        if (actual !== expected)
        begin
            count_errors++;
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compare_stat(input string name, input afu_pkg::eng_stat_t expected,
                                input afu_pkg::eng_stat_t actual);
        if (actual !== expected)
        begin
            stat_errors++;
            $display("mismatch at %0t: %s expected active %0b lines %0d sum %h",
                     $time, name, expected.active, expected.lines_done, expected.checksum);
            $display("    actual active %0b lines %0d sum %h",
                     actual.active, actual.lines_done, actual.checksum);
        end
    endtask

    // ==================================================
    // Engine helpers
    // ==================================================

    task automatic fill_line(input int addr, input logic [afu_pkg::DATA_W-1:0] data);
        fill_en      = 1'b1;
        fill_addr    = afu_pkg::HADDR_W'(addr);
        fill_data    = data;
        golden[addr] = data;
        next_cycle();
        fill_en = 1'b0;
    endtask

    // Two extra destination lines catch a run that writes past its end
    task automatic prepare_region(input int src, input int dst, input int n);
        for (int i = 0; i < n; i++)
        begin
            fill_line(src + i, lfsr_bits(afu_pkg::DATA_W));
        end
        for (int i = 0; i < n + 2; i++)
        begin
            fill_line(dst + i, addr_pattern(dst + i));
        end
    endtask

    task automatic program_engine(input int e, input int src, input int dst, input int n);
        mmio_write(eng_addr(e, afu_pkg::ENG_CSR_RD_BASE), afu_pkg::DATA_W'(src));
        mmio_write(eng_addr(e, afu_pkg::ENG_CSR_WR_BASE), afu_pkg::DATA_W'(dst));
        mmio_write(eng_addr(e, afu_pkg::ENG_CSR_NUM_LINES), afu_pkg::DATA_W'(n));
    endtask

    task automatic start_engine(input int e);
        mmio_write(eng_addr(e, afu_pkg::ENG_CSR_CTRL), afu_pkg::DATA_W'(1));
    endtask

    task automatic wait_idle(input int e);
        logic [afu_pkg::DATA_W-1:0] word;
        word = '1;
        while (word[afu_pkg::STAT_ACTIVE_BIT] == 1'b1)
        begin
            mmio_read(eng_addr(e, afu_pkg::ENG_CSR_CTRL), word);
        end
    endtask

    task automatic read_stat(input int e, output afu_pkg::eng_stat_t stat);
        logic [afu_pkg::DATA_W-1:0] word;
        logic [afu_pkg::DATA_W-1:0] sum;
        mmio_read(eng_addr(e, afu_pkg::ENG_CSR_CTRL), word);
        mmio_read(eng_addr(e, afu_pkg::ENG_CSR_CHECKSUM), sum);
        stat.active     = word[afu_pkg::STAT_ACTIVE_BIT];
        stat.lines_done = word[afu_pkg::STAT_LINES_LSB +: afu_pkg::CNT_W];
        stat.checksum   = sum;
    endtask

    // Destination must mirror the source while lines past the end keep their pattern
    task automatic check_copy(input int e, input int src, input int dst, input int n);
        afu_pkg::eng_stat_t expected;
        afu_pkg::eng_stat_t actual;
        wait_idle(e);
        expected            = '0;
        expected.lines_done = afu_pkg::CNT_W'(n);
        for (int i = 0; i < n; i++)
        begin
            expected.checksum ^= golden[src + i];
            compare_data($sformatf("dest line %h", dst + i), golden[src + i],
                         u_mem.mem[afu_pkg::HADDR_W'(dst + i)]);
        end
        for (int i = n; i < n + 2; i++)
        begin
            compare_data($sformatf("untouched line %h", dst + i), golden[dst + i],
                         u_mem.mem[afu_pkg::HADDR_W'(dst + i)]);
        end
        read_stat(e, actual);
        compare_stat($sformatf("engine %0d status", e), expected, actual);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic check_global_csrs();
        logic [afu_pkg::DATA_W-1:0] word;
        mmio_read(glob_addr(0), word);
        compare_data("test id low", afu_pkg::TEST_ID[63:0], word);
        mmio_read(glob_addr(1), word);
        compare_data("test id high", afu_pkg::TEST_ID[127:64], word);
        mmio_read(glob_addr(2), word);
        compare_data("engine count", afu_pkg::DATA_W'(afu_pkg::NUM_ENGINES), word);
        mmio_read(glob_addr(3), word);
        compare_data("unmapped global word 3", '0, word);
        mmio_read(glob_addr(127), word);
        compare_data("unmapped global word 127", '0, word);
        mmio_read(eng_addr(5, afu_pkg::ENG_CSR_WR_BASE), word);
        compare_data("missing engine 5", '0, word);
        // Out of reset each checksum carries its engine number in the top byte
        for (int e = 0; e < afu_pkg::NUM_ENGINES; e++)
        begin
            mmio_read(eng_addr(e, afu_pkg::ENG_CSR_CHECKSUM), word);
            compare_data($sformatf("engine %0d reset checksum", e), {8'(e), 56'h0}, word);
        end
    endtask

    task automatic check_config_readback();
        logic [afu_pkg::DATA_W-1:0] word;
        program_engine(0, 'h1111, 'h2222, 'h0033);
        program_engine(1, 'h4444, 'h5555, 'h0066);
        mmio_read(eng_addr(0, afu_pkg::ENG_CSR_RD_BASE_RB), word);
        compare_data("engine 0 rd_base", afu_pkg::DATA_W'(16'h1111), word);
        mmio_read(eng_addr(0, afu_pkg::ENG_CSR_WR_BASE), word);
        compare_data("engine 0 wr_base", afu_pkg::DATA_W'(16'h2222), word);
        mmio_read(eng_addr(0, afu_pkg::ENG_CSR_NUM_LINES), word);
        compare_count("engine 0 num_lines", 16'h0033, word[afu_pkg::CNT_W-1:0]);
        mmio_read(eng_addr(1, afu_pkg::ENG_CSR_RD_BASE_RB), word);
        compare_data("engine 1 rd_base", afu_pkg::DATA_W'(16'h4444), word);
        mmio_read(eng_addr(1, afu_pkg::ENG_CSR_WR_BASE), word);
        compare_data("engine 1 wr_base", afu_pkg::DATA_W'(16'h5555), word);
        mmio_read(eng_addr(1, afu_pkg::ENG_CSR_NUM_LINES), word);
        compare_count("engine 1 num_lines", 16'h0066, word[afu_pkg::CNT_W-1:0]);
    endtask

    task automatic run_single_copy();
        prepare_region('h0100, 'h0200, 8);
        program_engine(0, 'h0100, 'h0200, 8);
        start_engine(0);
        // Active rises on the edge after start and status is polled from then on
        next_cycle();
        check_copy(0, 'h0100, 'h0200, 8);
    endtask

    task automatic run_concurrent_copies();
        prepare_region('h0300, 'h0400, 12);
        prepare_region('h0500, 'h0600, 5);
        program_engine(0, 'h0300, 'h0400, 12);
        program_engine(1, 'h0500, 'h0600, 5);
        start_engine(0);
        start_engine(1);
        next_cycle();
        check_copy(0, 'h0300, 'h0400, 12);
        check_copy(1, 'h0500, 'h0600, 5);
    endtask

    task automatic run_edge_cases();
        logic [afu_pkg::DATA_W-1:0] word;
        // Zero lines clears the status and touches no memory
        prepare_region('h0700, 'h0800, 0);
        program_engine(1, 'h0700, 'h0800, 0);
        start_engine(1);
        next_cycle();
        check_copy(1, 'h0700, 'h0800, 0);

        // A start during a run is dropped so the first length holds
        prepare_region('h0900, 'h0a00, 10);
        program_engine(0, 'h0900, 'h0a00, 10);
        start_engine(0);
        next_cycle();
        mmio_read(eng_addr(0, afu_pkg::ENG_CSR_CTRL), word);
        if (word[afu_pkg::STAT_ACTIVE_BIT] !== 1'b1)
        begin
            other_errors++;
            $display("engine 0 was already idle before the second start");
        end
        mmio_write(eng_addr(0, afu_pkg::ENG_CSR_NUM_LINES), afu_pkg::DATA_W'(3));
        start_engine(0);
        next_cycle();
        check_copy(0, 'h0900, 'h0a00, 10);

        // A restart after a run must not carry over the old count and checksum
        prepare_region('h0b00, 'h0c00, 3);
        program_engine(0, 'h0b00, 'h0c00, 3);
        start_engine(0);
        next_cycle();
        check_copy(0, 'h0b00, 'h0c00, 3);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        lfsr         = 16'd16;
        data_errors  = 0;
        stat_errors  = 0;
        count_errors = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        mmio_req     = '0;
        fill_en      = 1'b0;
        fill_addr    = '0;
        fill_data    = '0;
        for (int p = 0; p < afu_pkg::NUM_ENGINES; p++)
        begin
            lat_sel[p] = 2'b00;
        end

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        check_global_csrs();
        check_config_readback();
        run_single_copy();
        run_concurrent_copies();
        run_edge_cases();

        print_error_counts();
        if (data_errors + stat_errors + count_errors + other_errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
